// File: design/rom_pkg.sv
// ROM subsystem shared definitions: region map, widths, payload types and request structs
package rom_pkg;

    // Address widths
    localparam int SDRAM_AW = 22;        // Counted in 16-bit words
    localparam int IOCTL_AW = 25;        // Download byte address
    localparam int MAIN_AW  = 18;
    localparam int CHAR_AW  = 16;
    localparam int SCR_AW   = 17;

    // Where each region sits in the download stream
    localparam logic [IOCTL_AW-1:0] MAIN_LOAD = 25'h00000;
    localparam logic [IOCTL_AW-1:0] CHAR_LOAD = 25'h80000;
    localparam logic [IOCTL_AW-1:0] SCR_LOAD  = 25'h90000;

    // Region lengths in bytes
    localparam logic [IOCTL_AW-1:0] MAIN_LEN  = 25'h40000;
    localparam logic [IOCTL_AW-1:0] CHAR_LEN  = 25'h10000;
    localparam logic [IOCTL_AW-1:0] SCR_LEN   = 25'h40000;

    // Relocated SDRAM word addresses
    localparam logic [SDRAM_AW-1:0] MAIN_BASE = 22'h00000;
    localparam logic [SDRAM_AW-1:0] CHAR_BASE = 22'h40000;
    localparam logic [SDRAM_AW-1:0] SCR_BASE  = 22'h60000;

    // Reader slots, lowest index wins
    localparam int NSLOTS    = 3;
    localparam int SLOT_IW   = $clog2(NSLOTS);
    localparam int SLOT_MAIN = 0;
    localparam int SLOT_SCR  = 1;
    localparam int SLOT_CHAR = 2;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] half_t;
    typedef logic [31:0] sdram_word_t;

    // Slot to arbiter
    typedef struct packed {
        logic                req;
        logic [SDRAM_AW-1:0] addr;
    } slot_req_t;

    // Download write command towards SDRAM
    typedef struct packed {
        logic [SDRAM_AW-1:0] addr;
        byte_t               data;
        logic [1:0]          mask;   // 2'b10 writes the low byte
    } prog_wr_t;

endpackage

// File: design/rom_download.sv
// ROM download loader that relocates incoming bytes into SDRAM write commands
module rom_download import rom_pkg::*; (
    input  logic                clk48,
    input  logic                rst_n,
    input  logic                downloading,
    input  logic [IOCTL_AW-1:0] ioctl_addr,
    input  byte_t               ioctl_data,
    input  logic                ioctl_wr,
    input  logic                sdram_ack,
    output prog_wr_t            prog,
    output logic                prog_we
);

    logic [IOCTL_AW-1:0] offset;     // Byte offset inside the region
    logic [SDRAM_AW-1:0] base;
    logic                in_region;
    logic                load;
    prog_wr_t            cmd;

    // Region decode
    always_comb begin
        in_region = 1'b1;
        offset    = '0;
        base      = '0;
        if (ioctl_addr >= MAIN_LOAD && ioctl_addr < MAIN_LOAD + MAIN_LEN) begin
            offset = ioctl_addr - MAIN_LOAD;
            base   = MAIN_BASE;
        end else if (ioctl_addr >= CHAR_LOAD && ioctl_addr < CHAR_LOAD + CHAR_LEN) begin
            offset = ioctl_addr - CHAR_LOAD;
            base   = CHAR_BASE;
        end else if (ioctl_addr >= SCR_LOAD && ioctl_addr < SCR_LOAD + SCR_LEN) begin
            offset = ioctl_addr - SCR_LOAD;
            base   = SCR_BASE;
        end else begin
            in_region = 1'b0;        // Gap between regions, byte dropped
        end
    end

    always_comb begin
        cmd.addr = base + offset[SDRAM_AW:1];
        cmd.data = ioctl_data;
        cmd.mask = ioctl_addr[0] ? 2'b01 : 2'b10;
    end

    assign load = downloading && ioctl_wr && in_region;

    always_ff @(posedge clk48 or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
        end else if (load) begin
            prog_we <= 1'b1;
        end else if (sdram_ack) begin
            prog_we <= 1'b0;         // Low on the cycle after the ack
        end
    end

    always_ff @(posedge clk48) begin
        if (load) prog <= cmd;
    end

    // Host must not overwrite a command the SDRAM has not taken yet
    a_prog_held: assert property (@(posedge clk48) disable iff (!rst_n)
        prog_we && !sdram_ack |=> prog_we && $stable(prog));

endmodule

// File: design/rom_slot.sv
// ROM reader slot with a one-word cache that requests SDRAM only on a miss
module rom_slot import rom_pkg::*; #(
    parameter int                  AW     = 16,
    parameter type                 data_t = byte_t,
    parameter logic [SDRAM_AW-1:0] BASE   = '0
) (
    input  logic          clk48,
    input  logic          rst_n,
    input  logic          cs,
    input  logic [AW-1:0] addr,
    input  logic          done,
    input  sdram_word_t   rdata,
    output logic          ok,
    output data_t         data,
    output slot_req_t     request
);

    logic [AW-1:0]       tag;        // Address of the cached or pending word
    logic                valid;
    logic                req_q;
    logic                ok_q;
    logic                hit;
    logic                miss;
    logic [SDRAM_AW-1:0] word_off;
    data_t               fetched;
    data_t               data_q;

    assign hit  = valid && (tag == addr);
    assign miss = cs && !req_q && !hit;

    // Byte slots pack two entries per SDRAM word
    always_comb begin
        if ($bits(data_t) == $bits(byte_t)) begin
            word_off = SDRAM_AW'(tag >> 1);
        end else begin
            word_off = SDRAM_AW'(tag);
        end
    end

    always_comb begin
        if ($bits(data_t) == $bits(byte_t) && tag[0]) begin
            fetched = data_t'(rdata[15:8]);   // Odd byte
        end else begin
            fetched = data_t'(rdata[$bits(data_t)-1:0]);
        end
    end

    always_comb begin
        request.req  = req_q;
        request.addr = BASE + word_off;
    end

    always_ff @(posedge clk48 or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
            req_q <= 1'b0;
            ok_q  <= 1'b0;
        end else begin
            // Data written on done is usable right after
            ok_q <= cs && (valid || done) && (addr == tag);
            if (done) begin
                req_q <= 1'b0;
                valid <= 1'b1;
            end else if (miss) begin
                req_q <= 1'b1;
                valid <= 1'b0;   // Old word is about to be replaced
            end
        end
    end

    always_ff @(posedge clk48) begin
        if (miss) tag <= addr;
        if (done) data_q <= fetched;
    end

    // A stale ok from the previous address must not leak through
    assign ok   = ok_q && (addr == tag);
    assign data = data_q;

    // Data is only offered for a valid cached word that matches addr
    a_ok_match: assert property (@(posedge clk48) disable iff (!rst_n)
        ok |-> hit);

    // The arbiter may take several cycles to answer
    a_req_hold: assert property (@(posedge clk48) disable iff (!rst_n)
        request.req && !done |=> request.req && $stable(request.addr));

endmodule

// File: design/rom_arbiter.sv
// SDRAM read arbiter that serves one slot at a time by fixed priority and routes the data back
module rom_arbiter import rom_pkg::*; (
    input  logic                         clk48,
    input  logic                         rst_n,
    input  logic                         downloading,
    input  slot_req_t [NSLOTS-1:0]       requests,
    input  logic                         sdram_ack,
    input  logic                         data_rdy,
    input  sdram_word_t                  data_read,
    output logic                         sdram_req,
    output logic [SDRAM_AW-1:0]          sdram_addr,
    output logic [NSLOTS-1:0]            done,
    output sdram_word_t                  rdata
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_DATA
    } state_t;

    state_t              state;
    logic [NSLOTS-1:0]   pending;
    logic [SLOT_IW-1:0]  pick;
    logic [SLOT_IW-1:0]  granted;    // Slot that owns the transfer in flight
    logic                start;

    // A slot that just got done still shows req for one cycle
    always_comb begin
        for (int i = 0; i < NSLOTS; i++) begin
            pending[i] = requests[i].req && !done[i];
        end
    end

    // Lowest index wins
    always_comb begin
        pick = '0;
        for (int i = NSLOTS - 1; i >= 0; i--) begin
            if (pending[i]) pick = SLOT_IW'(i);
        end
    end

    assign start = (state == IDLE) && !downloading && (|pending);

    always_ff @(posedge clk48 or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            sdram_req <= 1'b0;
            granted   <= '0;
            done      <= '0;
        end else begin
            done <= '0;
            case (state)
                IDLE: begin
                    if (start) begin
                        granted   <= pick;
                        sdram_req <= 1'b1;
                        state     <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (data_rdy) begin
                        done[granted] <= 1'b1;
                        state         <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk48) begin
        if (start) sdram_addr <= requests[pick].addr;
        if (state == WAIT_DATA && data_rdy) rdata <= data_read;
    end

    // SDRAM controller latches the address only on ack
    a_req_stable: assert property (@(posedge clk48) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr));

    a_done_onehot: assert property (@(posedge clk48) disable iff (!rst_n)
        $onehot0(done));

    // Reads stay off the bus while the loader owns it
    a_no_req_dl: assert property (@(posedge clk48) disable iff (!rst_n)
        downloading && !sdram_req |=> !sdram_req);

endmodule

// File: design/rom_top.sv
// ROM access subsystem top: download loader, three cached readers and the SDRAM arbiter
module rom_top import rom_pkg::*; (
    input  logic                clk48,
    input  logic                rst_n,
    // Download port
    input  logic                downloading,
    input  logic [IOCTL_AW-1:0] ioctl_addr,
    input  byte_t               ioctl_data,
    input  logic                ioctl_wr,
    output prog_wr_t            prog,
    output logic                prog_we,
    // SDRAM
    output logic                sdram_req,
    output logic [SDRAM_AW-1:0] sdram_addr,
    input  logic                sdram_ack,
    input  logic                data_rdy,
    input  sdram_word_t         data_read,
    // Game side readers
    input  logic                main_cs,
    input  logic [MAIN_AW-1:0]  main_addr,
    output logic                main_ok,
    output byte_t               main_data,
    input  logic                char_cs,
    input  logic [CHAR_AW-1:0]  char_addr,
    output logic                char_ok,
    output byte_t               char_data,
    input  logic                scr_cs,
    input  logic [SCR_AW-1:0]   scr_addr,
    output logic                scr_ok,
    output half_t               scr_data
);

    slot_req_t [NSLOTS-1:0] requests;
    logic      [NSLOTS-1:0] done;
    sdram_word_t            rdata;    // Shared by all slots, qualified by done

    rom_download u_download (
        .clk48       ( clk48       ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prog        ( prog        ),
        .prog_we     ( prog_we     )
    );

    rom_slot #(.AW(MAIN_AW), .data_t(byte_t), .BASE(MAIN_BASE)) u_main (
        .clk48 ( clk48 ), .rst_n ( rst_n ), .cs ( main_cs ), .addr ( main_addr ),
        .done ( done[SLOT_MAIN] ), .rdata ( rdata ), .ok ( main_ok ),
        .data ( main_data ), .request ( requests[SLOT_MAIN] )
    );

    rom_slot #(.AW(SCR_AW), .data_t(half_t), .BASE(SCR_BASE)) u_scr (
        .clk48 ( clk48 ), .rst_n ( rst_n ), .cs ( scr_cs ), .addr ( scr_addr ),
        .done ( done[SLOT_SCR] ), .rdata ( rdata ), .ok ( scr_ok ),
        .data ( scr_data ), .request ( requests[SLOT_SCR] )
    );

    rom_slot #(.AW(CHAR_AW), .data_t(byte_t), .BASE(CHAR_BASE)) u_char (
        .clk48 ( clk48 ), .rst_n ( rst_n ), .cs ( char_cs ), .addr ( char_addr ),
        .done ( done[SLOT_CHAR] ), .rdata ( rdata ), .ok ( char_ok ),
        .data ( char_data ), .request ( requests[SLOT_CHAR] )
    );

    rom_arbiter u_arbiter (
        .clk48       ( clk48       ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .requests    ( requests    ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .done        ( done        ),
        .rdata       ( rdata       )
    );

endmodule

// File: verification/rom_checker.sv
// ROM subsystem scoreboard that predicts relocated writes and read data and checks the SDRAM handshake
module rom_checker import rom_pkg::*; (
    input  logic                clk48,
    input  logic                rst_n,
    input  int                  phase,
    input  logic                downloading,
    input  logic [IOCTL_AW-1:0] ioctl_addr,
    input  byte_t               ioctl_data,
    input  logic                ioctl_wr,
    input  prog_wr_t            prog,
    input  logic                prog_we,
    input  logic                sdram_req,
    input  logic [SDRAM_AW-1:0] sdram_addr,
    input  logic                sdram_ack,
    input  logic                main_cs,
    input  logic [MAIN_AW-1:0]  main_addr,
    input  logic                main_ok,
    input  byte_t               main_data,
    input  logic                char_cs,
    input  logic [CHAR_AW-1:0]  char_addr,
    input  logic                char_ok,
    input  byte_t               char_data,
    input  logic                scr_cs,
    input  logic [SCR_AW-1:0]   scr_addr,
    input  logic                scr_ok,
    input  half_t               scr_data,
    output sdram_word_t         model_data,
    output int                  errors,
    output int                  tests_failed
);

    int                  last_phase  = 0;
    int                  phase_errs  = 0;
    int                  order_idx   = 0;   // Requests seen since the addresses changed
    logic                dl_due      = 1'b0;
    logic                dl_in       = 1'b0;
    prog_wr_t            dl_exp;
    logic                req_q       = 1'b0;
    logic                ack_q       = 1'b0;
    logic [SDRAM_AW-1:0] addr_q;
    logic [MAIN_AW-1:0]  main_q;
    logic                held        = 1'b0;
    sdram_word_t         w;
    logic [SDRAM_AW-1:0] want;

    initial begin
        errors       = 0;
        tests_failed = 0;
    end

    // Content of every SDRAM word, depends on all address bits
    function automatic sdram_word_t model_word(input logic [SDRAM_AW-1:0] a);
        return {a[9:0], a} ^ 32'h6c8e_9cf5;
    endfunction

    function automatic byte_t byte_of(input sdram_word_t wd, input logic odd);
        return odd ? wd[15:8] : wd[7:0];
    endfunction

    function automatic string test_name(input int p);
        case (p)
            1:       return "reset";
            2:       return "download";
            3:       return "random_reads";
            4:       return "simultaneous_misses";
            5:       return "repeated_reads";
            6:       return "delayed_ack";
            default: return "idle";
        endcase
    endfunction

    // Region decode and relocation, straight from the region map
    function automatic logic relocate(input logic [IOCTL_AW-1:0] a, input byte_t d,
                                      output prog_wr_t cmd);
        logic [IOCTL_AW-1:0] off;
        logic [SDRAM_AW-1:0] base;
        if (a >= MAIN_LOAD && a < MAIN_LOAD + MAIN_LEN) begin
            off  = a - MAIN_LOAD;
            base = MAIN_BASE;
        end else if (a >= CHAR_LOAD && a < CHAR_LOAD + CHAR_LEN) begin
            off  = a - CHAR_LOAD;
            base = CHAR_BASE;
        end else if (a >= SCR_LOAD && a < SCR_LOAD + SCR_LEN) begin
            off  = a - SCR_LOAD;
            base = SCR_BASE;
        end else begin
            cmd = '0;
            return 1'b0;
        end
        cmd.addr = base + SDRAM_AW'(off / 2);
        cmd.data = d;
        cmd.mask = a[0] ? 2'b01 : 2'b10;
        return 1'b1;
    endfunction

    task automatic fail_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("ERROR %s: %s expected %h actual %h", test_name(phase), what, exp, act);
        errors++;
        phase_errs++;
    endtask

    task automatic fail_text(input string msg);
        $display("%s: %s", test_name(phase), msg);
        errors++;
        phase_errs++;
    endtask

    assign model_data = model_word(sdram_addr);

    always @(posedge clk48) begin
        if (phase != last_phase) begin
            if (last_phase >= 1 && last_phase <= 6) begin
                if (phase_errs == 0) begin
                    $display("%s: ok", test_name(last_phase));
                end else begin
                    $display("%s: FAILED with %0d errors", test_name(last_phase), phase_errs);
                    tests_failed++;
                end
            end
            last_phase = phase;
            phase_errs = 0;
            order_idx  = 0;
            held       = 1'b0;
        end
        if (!rst_n) begin
            if (phase == 1 && (sdram_req || prog_we || main_ok || char_ok || scr_ok))
                fail_text("an output is high during reset");
        end else begin
            // Write command one cycle after the download byte
            if (dl_due) begin
                if (dl_in && !prog_we)
                    fail_text("no write command after an in-region byte");
                else if (dl_in && prog != dl_exp)
                    fail_value("prog", 32'(dl_exp), 32'(prog));
                else if (!dl_in && prog_we)
                    fail_text("write command issued for a byte in a gap");
            end
            dl_due = downloading && ioctl_wr;
            if (dl_due) dl_in = relocate(ioctl_addr, ioctl_data, dl_exp);
            if (downloading && sdram_req)
                fail_text("read request issued during download");

            // Request and address held until the ack
            if (req_q && !ack_q) begin
                if (!sdram_req)
                    fail_text("sdram_req dropped before the ack");
                else if (sdram_addr != addr_q)
                    fail_value("sdram_addr", 32'(addr_q), 32'(sdram_addr));
            end

            if (main_cs && main_ok) begin
                w = model_word(MAIN_BASE + SDRAM_AW'(main_addr >> 1));
                if (main_data != byte_of(w, main_addr[0]))
                    fail_value("main_data", 32'(byte_of(w, main_addr[0])), 32'(main_data));
            end
            if (char_cs && char_ok) begin
                w = model_word(CHAR_BASE + SDRAM_AW'(char_addr >> 1));
                if (char_data != byte_of(w, char_addr[0]))
                    fail_value("char_data", 32'(byte_of(w, char_addr[0])), 32'(char_data));
            end
            if (scr_cs && scr_ok) begin
                w = model_word(SCR_BASE + SDRAM_AW'(scr_addr));
                if (scr_data != w[15:0])
                    fail_value("scr_data", 32'(w[15:0]), 32'(scr_data));
            end

            // Main, then scroll, then char
            if (phase == 4) begin
                if (main_addr != main_q) order_idx = 0;
                if (sdram_req && !req_q) begin
                    case (order_idx)
                        0:       want = MAIN_BASE + SDRAM_AW'(main_addr >> 1);
                        1:       want = SCR_BASE + SDRAM_AW'(scr_addr);
                        default: want = CHAR_BASE + SDRAM_AW'(char_addr >> 1);
                    endcase
                    if (order_idx < 3 && sdram_addr != want)
                        fail_value("sdram_addr order", 32'(want), 32'(sdram_addr));
                    order_idx++;
                end
            end

            if (phase == 5) begin
                if (main_addr != main_q) held = 1'b0;
                if (held && !main_ok)
                    fail_text("main_ok dropped on a repeated read");
                if (held && sdram_req && !req_q)
                    fail_text("repeated read went to SDRAM again");
                if (main_ok) held = 1'b1;
            end
        end
        req_q  = sdram_req;
        ack_q  = sdram_ack;
        addr_q = sdram_addr;
        main_q = main_addr;
    end

endmodule

// File: verification/rom_tb.sv
// ROM subsystem testbench with LCG stimulus, an SDRAM model and a watchdog
module rom_tb import rom_pkg::*; ();

    localparam int N_DL   = 300;
    localparam int N_RD   = 200;
    localparam int N_SIM  = 20;
    localparam int N_REP  = 10;
    localparam int N_DLY  = 20;
    localparam int LIMIT  = (N_DL + N_RD + N_SIM + N_REP + N_DLY + 1) * 200;

    logic                clk48;
    logic                rst_n;
    logic                downloading;
    logic [IOCTL_AW-1:0] ioctl_addr;
    byte_t               ioctl_data;
    logic                ioctl_wr;
    prog_wr_t            prog;
    logic                prog_we;
    logic                sdram_req;
    logic [SDRAM_AW-1:0] sdram_addr;
    logic                sdram_ack;
    logic                data_rdy;
    sdram_word_t         data_read;
    sdram_word_t         model_data;
    logic                main_cs, char_cs, scr_cs;
    logic [MAIN_AW-1:0]  main_addr;
    logic [CHAR_AW-1:0]  char_addr;
    logic [SCR_AW-1:0]   scr_addr;
    logic                main_ok, char_ok, scr_ok;
    byte_t               main_data, char_data;
    half_t               scr_data;
    int                  phase;
    int                  errors;
    int                  tests_failed;
    int                  ack_max;
    logic [31:0]         seed = 32'd47;

    rom_top uut (.*);

    rom_checker chk (.*);

    function automatic int unsigned rand_below(input int unsigned n);
        seed = seed * 32'd1103515245 + 32'd12345;
        return (seed >> 8) % n;
    endfunction

    initial begin
        clk48 = 1'b0;
        forever #5 clk48 = ~clk48;
    end

    // SDRAM answers one request at a time
    initial begin : sdram_model
        int d;
        forever begin
            @(posedge clk48);
            if (rst_n && (sdram_req || prog_we)) begin
                d = 1 + rand_below(ack_max);
                repeat (d - 1) @(posedge clk48);
                sdram_ack <= 1'b1;
                @(posedge clk48);
                sdram_ack <= 1'b0;
                if (!downloading) begin
                    d = 1 + rand_below(8);
                    repeat (d - 1) @(posedge clk48);
                    data_rdy  <= 1'b1;
                    data_read <= model_data;
                    @(posedge clk48);
                    data_rdy  <= 1'b0;
                end
            end
        end
    end

    initial begin
        repeat (LIMIT) @(posedge clk48);
        $display("Timeout: run did not finish within %0d cycles", LIMIT);
        $display("test failed");
        $finish;
    end

    function automatic logic slot_ok(input int s);
        case (s)
            SLOT_MAIN: return main_ok;
            SLOT_SCR:  return scr_ok;
            default:   return char_ok;
        endcase
    endfunction

    task automatic read_one(input int s);
        main_cs <= (s == SLOT_MAIN);
        scr_cs  <= (s == SLOT_SCR);
        char_cs <= (s == SLOT_CHAR);
        if (s == SLOT_MAIN) main_addr <= MAIN_AW'(rand_below(1 << MAIN_AW));
        if (s == SLOT_SCR)  scr_addr  <= SCR_AW'(rand_below(1 << SCR_AW));
        if (s == SLOT_CHAR) char_addr <= CHAR_AW'(rand_below(1 << CHAR_AW));
        do @(posedge clk48); while (!slot_ok(s));
    endtask

    task automatic download_byte();
        case (rand_below(4))
            0:       ioctl_addr <= MAIN_LOAD + IOCTL_AW'(rand_below(MAIN_LEN));
            1:       ioctl_addr <= CHAR_LOAD + IOCTL_AW'(rand_below(CHAR_LEN));
            2:       ioctl_addr <= SCR_LOAD + IOCTL_AW'(rand_below(SCR_LEN));
            default: ioctl_addr <= MAIN_LOAD + MAIN_LEN + IOCTL_AW'(rand_below(25'h40000));
        endcase
        ioctl_data <= byte_t'(rand_below(256));
        ioctl_wr   <= 1'b1;
        @(posedge clk48);
        ioctl_wr <= 1'b0;
        @(posedge clk48);
        while (prog_we) @(posedge clk48);
    endtask

    task automatic read_all_at_once();
        logic [2:0] seen;
        seen = '0;
        main_addr <= main_addr + MAIN_AW'(1 + rand_below(1000));
        scr_addr  <= scr_addr + SCR_AW'(1 + rand_below(1000));
        char_addr <= char_addr + CHAR_AW'(1 + rand_below(1000));
        main_cs   <= 1'b1;
        scr_cs    <= 1'b1;
        char_cs   <= 1'b1;
        while (seen != 3'b111) begin
            @(posedge clk48);
            seen = seen | {char_ok, scr_ok, main_ok};
        end
    endtask

    initial begin
        rst_n = 1'b0;
        downloading = 1'b0;
        ioctl_addr = '0;
        ioctl_data = '0;
        ioctl_wr = 1'b0;
        sdram_ack = 1'b0;
        data_rdy = 1'b0;
        data_read = '0;
        main_cs = 1'b0;
        char_cs = 1'b0;
        scr_cs = 1'b0;
        main_addr = '0;
        char_addr = '0;
        scr_addr = '0;
        ack_max = 8;
        phase = 1;
        repeat (16) @(posedge clk48);
        rst_n <= 1'b1;
        @(posedge clk48);

        phase       <= 2;
        downloading <= 1'b1;
        main_cs     <= 1'b1;    // Misses that must wait for the download
        scr_cs      <= 1'b1;
        char_cs     <= 1'b1;
        repeat (N_DL) download_byte();
        downloading <= 1'b0;

        phase <= 3;
        repeat (N_RD) read_one(int'(rand_below(NSLOTS)));

        phase <= 4;
        repeat (N_SIM) read_all_at_once();

        phase   <= 5;
        scr_cs  <= 1'b0;
        char_cs <= 1'b0;
        repeat (N_REP) begin
            read_one(SLOT_MAIN);
            repeat (20) @(posedge clk48);   // Same address, must stay a hit
        end

        phase   <= 6;
        ack_max <= 40;
        repeat (N_DLY) read_one(int'(rand_below(NSLOTS)));

        phase <= 7;
        repeat (2) @(posedge clk48);
        @(negedge clk48);
        $display("Tests: 6 run, %0d failed, %0d errors", tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: list.f
design/rom_pkg.sv
design/rom_download.sv
design/rom_slot.sv
design/rom_arbiter.sv
design/rom_top.sv
verification/rom_checker.sv
verification/rom_tb.sv

// File: Bender.yml
package:
  name: rom_access

sources:
  - files:
      - design/rom_pkg.sv
      - design/rom_download.sv
      - design/rom_slot.sv
      - design/rom_arbiter.sv
      - design/rom_top.sv
  - target: test
    files:
      - verification/rom_checker.sv
      - verification/rom_tb.sv
